// File: project.f
rvv_alu_pkg.sv
rvv_alu_rs_fifo.sv
rvv_alu_decode.sv
rvv_alu_execute.sv
rvv_alu_result.sv
rvv_alu.sv
rvv_alu_top.sv
rvv_alu_assertions.sv
tb_rvv_alu_top.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the RVV ALU regression
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_rvv_alu_top -f project.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "Regression passed" && exit 0 || exit 1

// File: tb_rvv_alu_top.sv
/*
  Testbench for the RVV ALU execution cluster
  Random uops from an xorshift source, a reference model of the
  element-wise ops and in-order issue, and a ROB with random ready.
*/

`timescale 1ns/1ps

module tb_rvv_alu_top;
  import rvv_alu_pkg::*;

  localparam int reset_cycles = 16;
  localparam int n_arith      = 48;
  localparam int n_other      = 64;
  localparam int n_dual       = 24;
  localparam int n_bp         = 64;
  localparam int total_pushes = n_arith + n_other + n_dual + n_bp;
  // 40 cycles of 4 ns for every push
  localparam int watchdog_ns  = total_pushes * 40 * 4;

  logic              clk;
  logic              rst;
  logic              push;
  logic [op_w-1:0]   in_op;
  logic [sew_w-1:0]  in_sew;
  logic [vlen_w-1:0] in_vs1;
  logic [vlen_w-1:0] in_vs2;
  logic [rob_w-1:0]  in_rob_entry;
  logic              full;
  logic              result0_valid;
  vec_word_u         result0_data;
  logic [rob_w-1:0]  result0_rob_entry;
  logic              result0_ready;
  logic              result1_valid;
  vec_word_u         result1_data;
  logic [rob_w-1:0]  result1_rob_entry;
  logic              result1_ready;

  // model of the reservation station contents and the two slots
  logic [31:0]       rng;
  logic [rob_w-1:0]  order_q [$];
  vec_word_u         exp_word [1 << rob_w];
  logic              live [1 << rob_w];
  logic              slot_valid [2];
  logic [rob_w-1:0]  slot_tag [2];
  logic [rob_w-1:0]  next_tag;
  logic              pend;
  logic              seen_full;
  logic              full_hit;
  int                pushes_left;
  int                ready_mode;
  int                op_mode;
  int                pushed;
  int                returned;
  int                delivered;
  int                checks;
  int                errors;
  int                tests;

  rvv_alu_top i_rvv_alu_top (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // element-wise reference, vs2 is the left operand
  function automatic vec_word_u expected_word(input logic [op_w-1:0] op,
      input logic [sew_w-1:0] sew, input logic [vlen_w-1:0] vs1,
      input logic [vlen_w-1:0] vs2);
    vec_word_u   e;
    logic [63:0] mask;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    logic [63:0] acc;
    int          ew;
    int          sh;
    ew = (sew == sew_8) ? 8 : (sew == sew_16) ? 16 : 32;
    mask = (64'd1 << ew) - 64'd1;
    acc = '0;
    for (int i = 0; i < vlen_w / ew; i++) begin
      a = (64'(vs2) >> (i * ew)) & mask;
      b = (64'(vs1) >> (i * ew)) & mask;
      sh = int'(b % 64'(ew));
      case (op)
        op_add:  r = a + b;
        op_sub:  r = a - b;
        op_and:  r = a & b;
        op_or:   r = a | b;
        op_xor:  r = a ^ b;
        op_minu: r = (a < b) ? a : b;
        op_maxu: r = (a > b) ? a : b;
        default: r = a << sh;
      endcase
      acc = acc | ((r & mask) << (i * ew));
    end
    e.w = acc[vlen_w-1:0];
    return e;
  endfunction

  task automatic check_word(input string name, input vec_word_u got, input vec_word_u exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got.w, exp.w);
      errors++;
    end
  endtask

  task automatic check_tag(input string name, input logic [rob_w-1:0] got,
      input logic [rob_w-1:0] exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic deliver(input int lane, input vec_word_u data, input logic [rob_w-1:0] tag);
    returned++;
    if (!live[tag]) begin
      $display("lane %0d returned tag %0d, which is not outstanding", lane, tag);
      errors++;
    end else begin
      check_word($sformatf("result%0d_data", lane), data, exp_word[tag]);
      // older uop goes to lane 0, so the issue order fixes the tag
      check_tag($sformatf("result%0d_rob_entry", lane), tag, slot_tag[lane]);
      live[tag] = 1'b0;
      delivered++;
    end
  endtask

  task automatic update_slot(input int n, input logic load, input logic rdy);
    if (load) begin
      slot_valid[n] = 1'b1;
      slot_tag[n] = order_q.pop_front();
    end else if (slot_valid[n] && rdy) begin
      slot_valid[n] = 1'b0;
    end
  endtask

  // one clock: check, advance the model, drive the next inputs
  task automatic step();
    logic pop0_m;
    logic pop1_m;
    int   fill;
    @(posedge clk);
    fill = order_q.size();
    check_flag("full", full, fill == rs_depth);
    check_flag("result0_valid", result0_valid, slot_valid[0]);
    check_flag("result1_valid", result1_valid, slot_valid[1]);
    if (full)
      full_hit = 1'b1;
    if (result0_valid && result0_ready)
      deliver(0, result0_data, result0_rob_entry);
    if (result1_valid && result1_ready)
      deliver(1, result1_data, result1_rob_entry);
    pop0_m = (fill > 0) && (!slot_valid[0] || result0_ready);
    pop1_m = pop0_m && (fill > 1) && (!slot_valid[1] || result1_ready);
    update_slot(0, pop0_m, result0_ready);
    update_slot(1, pop1_m, result1_ready);
    if (push) begin
      exp_word[in_rob_entry] = expected_word(in_op, in_sew, in_vs1, in_vs2);
      live[in_rob_entry] = 1'b1;
      order_q.push_back(in_rob_entry);
      pushed++;
    end
    if (order_q.size() == rs_depth)
      seen_full = 1'b1;
    rng = xorshift(rng);
    pend = (pushes_left > 0) && (order_q.size() < rs_depth) &&
           (ready_mode == 2 || rng[1:0] != 2'b00);
    push <= pend;
    if (pend) begin
      if (op_mode == 0)
        in_op <= rng[4] ? op_sub : op_add;
      else if (op_mode == 1)
        in_op <= op_w'(32'd2 + rng % 32'd6);
      else
        in_op <= rng[6:4];
      in_sew <= rng[9:8];
      in_rob_entry <= next_tag;
      rng = xorshift(rng);
      in_vs1 <= rng;
      rng = xorshift(rng);
      in_vs2 <= rng;
      next_tag = next_tag + 1'b1;
      pushes_left--;
    end
    rng = xorshift(rng);
    case (ready_mode)
      0: begin
        result0_ready <= 1'b1;
        result1_ready <= 1'b1;
      end
      1: begin
        result0_ready <= rng[12];
        result1_ready <= rng[20];
      end
      // hold the ROB off until the station has filled
      default: begin
        result0_ready <= seen_full;
        result1_ready <= seen_full;
      end
    endcase
  endtask

  task automatic run_phase(input string name, input int n, input int rmode, input int omode);
    int err0;
    int del0;
    err0 = errors;
    del0 = delivered;
    pushes_left = n;
    ready_mode = rmode;
    op_mode = omode;
    seen_full = 1'b0;
    full_hit = 1'b0;
    do
      step();
    while (pushes_left > 0 || pend || delivered != pushed);
    if (rmode == 2 && !full_hit) begin
      $display("%s: the reservation station never became full", name);
      errors++;
    end
    tests++;
    $display("test %-14s pushes %0d results %0d errors %0d", name, n, delivered - del0,
             errors - err0);
  endtask

  task automatic test_reset();
    int err0;
    err0 = errors;
    pushes_left = 0;
    ready_mode = 0;
    repeat (8) step();
    if (returned != 0) begin
      $display("results were delivered before any push");
      errors++;
    end
    tests++;
    $display("test %-14s errors %0d", "reset_state", errors - err0);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    push = 1'b0;
    in_op = '0;
    in_sew = '0;
    in_vs1 = '0;
    in_vs2 = '0;
    in_rob_entry = '0;
    result0_ready = 1'b0;
    result1_ready = 1'b0;
    rng = 32'd6;
    next_tag = '0;
    pend = 1'b0;
    seen_full = 1'b0;
    full_hit = 1'b0;
    pushed = 0;
    returned = 0;
    delivered = 0;
    checks = 0;
    errors = 0;
    tests = 0;
    slot_valid[0] = 1'b0;
    slot_valid[1] = 1'b0;
    for (int i = 0; i < (1 << rob_w); i++)
      live[i] = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    run_phase("arith", n_arith, 0, 0);
    run_phase("logic_shift", n_other, 1, 1);
    run_phase("dual_issue", n_dual, 2, 2);
    run_phase("back_pressure", n_bp, 1, 2);
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("timeout after %0d ns with %0d results outstanding", watchdog_ns,
             pushed - delivered);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: rvv_alu_assertions.sv
/*
  RVV ALU cluster protocol checks
  Issue order, push against full, result hold under back-pressure
  and result state right after reset.
*/

`timescale 1ns/1ps

module rvv_alu_assertions (
  input logic                          clk,
  input logic                          rst,
  input logic                          push,
  input logic                          full,
  input logic                          pop0,
  input logic                          pop1,
  input logic                          result0_valid,
  input logic                          result0_ready,
  input rvv_alu_pkg::vec_word_u        result0_data,
  input logic [rvv_alu_pkg::rob_w-1:0] result0_rob_entry,
  input logic                          result1_valid,
  input logic                          result1_ready,
  input rvv_alu_pkg::vec_word_u        result1_data,
  input logic [rvv_alu_pkg::rob_w-1:0] result1_rob_entry
);

  // lane 1 never issues alone
  a_pop_order: assert property (@(posedge clk) disable iff (rst) pop1 |-> pop0)
    else $error("pop1 asserted without pop0");

  a_push_full: assert property (@(posedge clk) disable iff (rst) !(push && full))
    else $error("push while the reservation station is full");

  a_hold0: assert property (@(posedge clk) disable iff (rst)
    (result0_valid && !result0_ready) |=>
    (result0_valid && $stable(result0_data) && $stable(result0_rob_entry)))
    else $error("lane 0 result changed while stalled");

  a_hold1: assert property (@(posedge clk) disable iff (rst)
    (result1_valid && !result1_ready) |=>
    (result1_valid && $stable(result1_data) && $stable(result1_rob_entry)))
    else $error("lane 1 result changed while stalled");

  a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> !result0_valid && !result1_valid)
    else $error("result valid high right after reset");

endmodule

bind rvv_alu_top rvv_alu_assertions i_rvv_alu_assertions (
  .clk               (clk),
  .rst               (rst),
  .push              (push),
  .full              (full),
  .pop0              (pop0),
  .pop1              (pop1),
  .result0_valid     (result0_valid),
  .result0_ready     (result0_ready),
  .result0_data      (result0_data),
  .result0_rob_entry (result0_rob_entry),
  .result1_valid     (result1_valid),
  .result1_ready     (result1_ready),
  .result1_data      (result1_data),
  .result1_rob_entry (result1_rob_entry)
);

// File: rvv_alu_top.sv
/*
  RVV ALU execution cluster top
  Reservation station feeding the two-lane ALU, results to the ROB.
*/

`timescale 1ns/1ps

module rvv_alu_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            push,
  input  logic [rvv_alu_pkg::op_w-1:0]    in_op,
  input  logic [rvv_alu_pkg::sew_w-1:0]   in_sew,
  input  logic [rvv_alu_pkg::vlen_w-1:0]  in_vs1,
  input  logic [rvv_alu_pkg::vlen_w-1:0]  in_vs2,
  input  logic [rvv_alu_pkg::rob_w-1:0]   in_rob_entry,
  output logic                            full,
  output logic                            result0_valid,
  output rvv_alu_pkg::vec_word_u          result0_data,
  output logic [rvv_alu_pkg::rob_w-1:0]   result0_rob_entry,
  input  logic                            result0_ready,
  output logic                            result1_valid,
  output rvv_alu_pkg::vec_word_u          result1_data,
  output logic [rvv_alu_pkg::rob_w-1:0]   result1_rob_entry,
  input  logic                            result1_ready
);
  import rvv_alu_pkg::*;

  // reservation station to ALU
  logic               pop0;
  logic               pop1;
  logic               fifo_empty;
  logic               fifo_1left;
  logic [op_w-1:0]    uop0_op;
  logic [sew_w-1:0]   uop0_sew;
  logic [vlen_w-1:0]  uop0_vs1;
  logic [vlen_w-1:0]  uop0_vs2;
  logic [rob_w-1:0]   uop0_rob_entry;
  logic [op_w-1:0]    uop1_op;
  logic [sew_w-1:0]   uop1_sew;
  logic [vlen_w-1:0]  uop1_vs1;
  logic [vlen_w-1:0]  uop1_vs2;
  logic [rob_w-1:0]   uop1_rob_entry;

  rvv_alu_rs_fifo i_rs_fifo (.*);

  rvv_alu i_alu (.*);

endmodule

// File: rvv_alu.sv
/*
  RVV two-lane ALU
  Issues up to two uops per cycle in order from the reservation
  station, each lane with decode, execute and a result slot.
*/

`timescale 1ns/1ps

module rvv_alu (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            fifo_empty,
  input  logic                            fifo_1left,
  input  logic [rvv_alu_pkg::op_w-1:0]    uop0_op,
  input  logic [rvv_alu_pkg::sew_w-1:0]   uop0_sew,
  input  logic [rvv_alu_pkg::vlen_w-1:0]  uop0_vs1,
  input  logic [rvv_alu_pkg::vlen_w-1:0]  uop0_vs2,
  input  logic [rvv_alu_pkg::rob_w-1:0]   uop0_rob_entry,
  input  logic [rvv_alu_pkg::op_w-1:0]    uop1_op,
  input  logic [rvv_alu_pkg::sew_w-1:0]   uop1_sew,
  input  logic [rvv_alu_pkg::vlen_w-1:0]  uop1_vs1,
  input  logic [rvv_alu_pkg::vlen_w-1:0]  uop1_vs2,
  input  logic [rvv_alu_pkg::rob_w-1:0]   uop1_rob_entry,
  input  logic                            result0_ready,
  input  logic                            result1_ready,
  output logic                            pop0,
  output logic                            pop1,
  output logic                            result0_valid,
  output rvv_alu_pkg::vec_word_u          result0_data,
  output logic [rvv_alu_pkg::rob_w-1:0]   result0_rob_entry,
  output logic                            result1_valid,
  output rvv_alu_pkg::vec_word_u          result1_data,
  output logic [rvv_alu_pkg::rob_w-1:0]   result1_rob_entry
);
  import rvv_alu_pkg::*;

  logic [op_w-1:0]    lane_op    [2];
  logic [sew_w-1:0]   lane_sew   [2];
  vec_word_u          lane_vs1   [2];
  vec_word_u          lane_vs2   [2];
  logic [rob_w-1:0]   lane_rob   [2];
  logic               lane_load  [2];
  logic               lane_ready [2];
  logic               lane_valid [2];
  logic               lane_accept[2];
  vec_word_u          lane_data  [2];
  logic [rob_w-1:0]   lane_tag   [2];

  // lane 1 only pairs with lane 0, keeping issue in order
  assign pop0 = !fifo_empty && lane_accept[0];
  assign pop1 = pop0 && !fifo_1left && lane_accept[1];

  assign lane_op[0]    = uop0_op;
  assign lane_op[1]    = uop1_op;
  assign lane_sew[0]   = uop0_sew;
  assign lane_sew[1]   = uop1_sew;
  assign lane_vs1[0]   = uop0_vs1;
  assign lane_vs1[1]   = uop1_vs1;
  assign lane_vs2[0]   = uop0_vs2;
  assign lane_vs2[1]   = uop1_vs2;
  assign lane_rob[0]   = uop0_rob_entry;
  assign lane_rob[1]   = uop1_rob_entry;
  assign lane_load[0]  = pop0;
  assign lane_load[1]  = pop1;
  assign lane_ready[0] = result0_ready;
  assign lane_ready[1] = result1_ready;

  assign result0_valid     = lane_valid[0];
  assign result0_data      = lane_data[0];
  assign result0_rob_entry = lane_tag[0];
  assign result1_valid     = lane_valid[1];
  assign result1_data      = lane_data[1];
  assign result1_rob_entry = lane_tag[1];

  for (genvar n = 0; n < 2; n++) begin : g_lane
    logic [cls_w-1:0]   cls;
    logic               sub_sel;
    logic               max_sel;
    logic [lfn_w-1:0]   logic_fn;
    logic [shamt_w-1:0] shamt_mask;
    vec_word_u          res;

    rvv_alu_decode i_decode (
      .op         (lane_op[n]),
      .sew        (lane_sew[n]),
      .cls        (cls),
      .sub_sel    (sub_sel),
      .max_sel    (max_sel),
      .logic_fn   (logic_fn),
      .shamt_mask (shamt_mask)
    );

    rvv_alu_execute i_execute (
      .sew        (lane_sew[n]),
      .cls        (cls),
      .sub_sel    (sub_sel),
      .max_sel    (max_sel),
      .logic_fn   (logic_fn),
      .shamt_mask (shamt_mask),
      .vs1        (lane_vs1[n]),
      .vs2        (lane_vs2[n]),
      .res        (res)
    );

    rvv_alu_result i_result (
      .clk            (clk),
      .rst            (rst),
      .load           (lane_load[n]),
      .res            (res),
      .rob_entry      (lane_rob[n]),
      .ready          (lane_ready[n]),
      .valid          (lane_valid[n]),
      .data           (lane_data[n]),
      .data_rob_entry (lane_tag[n]),
      .accept         (lane_accept[n])
    );
  end

endmodule

// File: rvv_alu_result.sv
/*
  RVV ALU result slot
  Holds one result and its ROB tag until the ROB takes it.
*/

`timescale 1ns/1ps

module rvv_alu_result (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          load,
  input  rvv_alu_pkg::vec_word_u        res,
  input  logic [rvv_alu_pkg::rob_w-1:0] rob_entry,
  input  logic                          ready,
  output logic                          valid,
  output rvv_alu_pkg::vec_word_u        data,
  output logic [rvv_alu_pkg::rob_w-1:0] data_rob_entry,
  output logic                          accept
);
  import rvv_alu_pkg::*;

  // free, or draining this cycle
  assign accept = !valid || ready;

  always_ff @(posedge clk) begin
    if (rst)
      valid <= 1'b0;
    else if (load)
      valid <= 1'b1;
    else if (valid && ready)
      valid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (load) begin
      data           <= res;
      data_rob_entry <= rob_entry;
    end
  end

endmodule

// File: rvv_alu_execute.sv
/*
  RVV ALU element-wise execute
  Add/sub, bitwise logic, unsigned min/max and shift left over the
  byte, halfword or word view. No carry crosses an element.
*/

`timescale 1ns/1ps

module rvv_alu_execute (
  input  logic [rvv_alu_pkg::sew_w-1:0]   sew,
  input  logic [rvv_alu_pkg::cls_w-1:0]   cls,
  input  logic                            sub_sel,
  input  logic                            max_sel,
  input  logic [rvv_alu_pkg::lfn_w-1:0]   logic_fn,
  input  logic [rvv_alu_pkg::shamt_w-1:0] shamt_mask,
  input  rvv_alu_pkg::vec_word_u          vs1,
  input  rvv_alu_pkg::vec_word_u          vs2,
  output rvv_alu_pkg::vec_word_u          res
);
  import rvv_alu_pkg::*;

  // one element, zero-extended operands, caller keeps the low bits
  function automatic logic [vlen_w-1:0] elem_op(
    input logic [vlen_w-1:0]  a,
    input logic [vlen_w-1:0]  b,
    input logic [cls_w-1:0]   c,
    input logic               sub,
    input logic               mx,
    input logic [lfn_w-1:0]   fn,
    input logic [shamt_w-1:0] mask
  );
    logic [vlen_w-1:0] r;
    logic              lt;
    lt = (a < b);
    case (c)
      cls_arith: r = sub ? (a - b) : (a + b);
      cls_logic: begin
        case (fn)
          lfn_and: r = a & b;
          lfn_or:  r = a | b;
          default: r = a ^ b;
        endcase
      end
      // min keeps a when smaller, max flips the pick
      cls_minmax: r = (lt ^ mx) ? a : b;
      default:    r = a << (b[shamt_w-1:0] & mask);
    endcase
    return r;
  endfunction

  always_comb begin
    logic [vlen_w-1:0] er;
    er  = '0;
    res = '0;
    case (sew)
      sew_8: begin
        for (int i = 0; i < vlen_w/8; i++) begin
          er = elem_op(vlen_w'(vs2.b[i]), vlen_w'(vs1.b[i]), cls, sub_sel, max_sel,
                       logic_fn, shamt_mask);
          res.b[i] = er[7:0];
        end
      end
      sew_16: begin
        for (int i = 0; i < vlen_w/16; i++) begin
          er = elem_op(vlen_w'(vs2.h[i]), vlen_w'(vs1.h[i]), cls, sub_sel, max_sel,
                       logic_fn, shamt_mask);
          res.h[i] = er[15:0];
        end
      end
      // sew_32 and the reserved code
      default: begin
        res.w = elem_op(vs2.w, vs1.w, cls, sub_sel, max_sel, logic_fn, shamt_mask);
      end
    endcase
  end

endmodule

// File: rvv_alu_decode.sv
/*
  RVV ALU uop decode
  Maps opcode to an operation class with its selects, and the
  element width to the shift amount mask.
*/

`timescale 1ns/1ps

module rvv_alu_decode (
  input  logic [rvv_alu_pkg::op_w-1:0]    op,
  input  logic [rvv_alu_pkg::sew_w-1:0]   sew,
  output logic [rvv_alu_pkg::cls_w-1:0]   cls,
  output logic                            sub_sel,
  output logic                            max_sel,
  output logic [rvv_alu_pkg::lfn_w-1:0]   logic_fn,
  output logic [rvv_alu_pkg::shamt_w-1:0] shamt_mask
);
  import rvv_alu_pkg::*;

  always_comb begin
    cls      = cls_arith;
    sub_sel  = 1'b0;
    max_sel  = 1'b0;
    logic_fn = lfn_and;
    case (op)
      op_add:  cls = cls_arith;
      op_sub: begin
        cls     = cls_arith;
        sub_sel = 1'b1;
      end
      op_and:  cls = cls_logic;
      op_or: begin
        cls      = cls_logic;
        logic_fn = lfn_or;
      end
      op_xor: begin
        cls      = cls_logic;
        logic_fn = lfn_xor;
      end
      op_minu: cls = cls_minmax;
      op_maxu: begin
        cls     = cls_minmax;
        max_sel = 1'b1;
      end
      default: cls = cls_shift;
    endcase
  end

  // shift amount limited to the element width
  always_comb begin
    case (sew)
      sew_8:   shamt_mask = 5'b00111;
      sew_16:  shamt_mask = 5'b01111;
      default: shamt_mask = 5'b11111;
    endcase
  end

endmodule

// File: rvv_alu_rs_fifo.sv
/*
  ALU reservation station
  Circular buffer with one push and up to two pops per cycle.
  Presents the two oldest uops plus empty and one-left flags.
*/

`timescale 1ns/1ps

module rvv_alu_rs_fifo (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            push,
  input  logic [rvv_alu_pkg::op_w-1:0]    in_op,
  input  logic [rvv_alu_pkg::sew_w-1:0]   in_sew,
  input  logic [rvv_alu_pkg::vlen_w-1:0]  in_vs1,
  input  logic [rvv_alu_pkg::vlen_w-1:0]  in_vs2,
  input  logic [rvv_alu_pkg::rob_w-1:0]   in_rob_entry,
  input  logic                            pop0,
  input  logic                            pop1,
  output logic                            full,
  output logic                            fifo_empty,
  output logic                            fifo_1left,
  output logic [rvv_alu_pkg::op_w-1:0]    uop0_op,
  output logic [rvv_alu_pkg::sew_w-1:0]   uop0_sew,
  output logic [rvv_alu_pkg::vlen_w-1:0]  uop0_vs1,
  output logic [rvv_alu_pkg::vlen_w-1:0]  uop0_vs2,
  output logic [rvv_alu_pkg::rob_w-1:0]   uop0_rob_entry,
  output logic [rvv_alu_pkg::op_w-1:0]    uop1_op,
  output logic [rvv_alu_pkg::sew_w-1:0]   uop1_sew,
  output logic [rvv_alu_pkg::vlen_w-1:0]  uop1_vs1,
  output logic [rvv_alu_pkg::vlen_w-1:0]  uop1_vs2,
  output logic [rvv_alu_pkg::rob_w-1:0]   uop1_rob_entry
);
  import rvv_alu_pkg::*;

  logic [op_w-1:0]     mem_op  [rs_depth];
  logic [sew_w-1:0]    mem_sew [rs_depth];
  logic [vlen_w-1:0]   mem_vs1 [rs_depth];
  logic [vlen_w-1:0]   mem_vs2 [rs_depth];
  logic [rob_w-1:0]    mem_rob [rs_depth];
  logic [rs_ptr_w-1:0] wr_ptr;
  logic [rs_ptr_w-1:0] rd_ptr;
  logic [rs_ptr_w-1:0] rd_ptr_nxt;
  logic [rs_cnt_w-1:0] count;
  logic                push_ok;
  logic [1:0]          pop_num;

  assign push_ok = push && !full;
  assign pop_num = {1'b0, pop0} + {1'b0, pop1};
  // depth is a power of two, so the pointer wraps by itself
  assign rd_ptr_nxt = rd_ptr + 1'b1;

  assign full       = (count == rs_cnt_w'(rs_depth));
  assign fifo_empty = (count == '0);
  assign fifo_1left = (count == rs_cnt_w'(1));

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem_op[wr_ptr]  <= in_op;
      mem_sew[wr_ptr] <= in_sew;
      mem_vs1[wr_ptr] <= in_vs1;
      mem_vs2[wr_ptr] <= in_vs2;
      mem_rob[wr_ptr] <= in_rob_entry;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok)
        wr_ptr <= wr_ptr + 1'b1;
      rd_ptr <= rd_ptr + rs_ptr_w'(pop_num);
      count  <= count + rs_cnt_w'(push_ok) - rs_cnt_w'(pop_num);
    end
  end

  // head and next-to-head
  assign uop0_op        = mem_op[rd_ptr];
  assign uop0_sew       = mem_sew[rd_ptr];
  assign uop0_vs1       = mem_vs1[rd_ptr];
  assign uop0_vs2       = mem_vs2[rd_ptr];
  assign uop0_rob_entry = mem_rob[rd_ptr];
  assign uop1_op        = mem_op[rd_ptr_nxt];
  assign uop1_sew       = mem_sew[rd_ptr_nxt];
  assign uop1_vs1       = mem_vs1[rd_ptr_nxt];
  assign uop1_vs2       = mem_vs2[rd_ptr_nxt];
  assign uop1_rob_entry = mem_rob[rd_ptr_nxt];

endmodule

// File: rvv_alu_pkg.sv
/*
  RVV ALU shared definitions
  Widths, opcode and element width codes, decoded operation classes
  and the vector word union read as bytes, halfwords or one word.
*/

package rvv_alu_pkg;

  // datapath and ROB sizes
  localparam int vlen_w   = 32;
  localparam int rob_w    = 4;
  localparam int shamt_w  = $clog2(vlen_w);

  // ALU reservation station
  localparam int rs_depth = 8;
  localparam int rs_ptr_w = $clog2(rs_depth);
  localparam int rs_cnt_w = rs_ptr_w + 1;

  // opcodes
  localparam int op_w = 3;
  localparam logic [op_w-1:0] op_add  = 3'd0;
  localparam logic [op_w-1:0] op_sub  = 3'd1;
  localparam logic [op_w-1:0] op_and  = 3'd2;
  localparam logic [op_w-1:0] op_or   = 3'd3;
  localparam logic [op_w-1:0] op_xor  = 3'd4;
  localparam logic [op_w-1:0] op_minu = 3'd5;
  localparam logic [op_w-1:0] op_maxu = 3'd6;
  localparam logic [op_w-1:0] op_sll  = 3'd7;

  // element width, code 3 is reserved and treated as 32 bit
  localparam int sew_w = 2;
  localparam logic [sew_w-1:0] sew_8  = 2'd0;
  localparam logic [sew_w-1:0] sew_16 = 2'd1;
  localparam logic [sew_w-1:0] sew_32 = 2'd2;

  // operation classes out of decode
  localparam int cls_w = 2;
  localparam logic [cls_w-1:0] cls_arith  = 2'd0;
  localparam logic [cls_w-1:0] cls_logic  = 2'd1;
  localparam logic [cls_w-1:0] cls_minmax = 2'd2;
  localparam logic [cls_w-1:0] cls_shift  = 2'd3;

  // bitwise function select
  localparam int lfn_w = 2;
  localparam logic [lfn_w-1:0] lfn_and = 2'd0;
  localparam logic [lfn_w-1:0] lfn_or  = 2'd1;
  localparam logic [lfn_w-1:0] lfn_xor = 2'd2;

  // one vector word, viewed per element width
  typedef union packed {
    logic [vlen_w/8-1:0][7:0]   b;
    logic [vlen_w/16-1:0][15:0] h;
    logic [vlen_w-1:0]          w;
  } vec_word_u;

endpackage
